//--- logic/regfile_pkg.sv
package regfile_pkg;

	// architectural register numbering
	localparam int REG_WIDTH = 5;
	localparam int N_REG = 2 ** REG_WIDTH;

	// reorder buffer tag carried by each register
	localparam int ROB_WIDTH = 4;

	// registers with a nonzero value out of reset
	localparam logic [REG_WIDTH-1:0] REG_SP = 5'd2; // stack pointer
	localparam logic [REG_WIDTH-1:0] REG_HP = 5'd3; // heap pointer

	localparam logic [31:0] REG_SP_INIT = 32'h000f_fff0;
	localparam logic [31:0] REG_HP_INIT = 32'h0010_0000;

endpackage

//--- logic/acc_pkg.sv
package acc_pkg;

	localparam int N_CORE = 4; // add requesters
	localparam int N_ACC = 2; // accumulators at the top of the register file

	// signed issue stamp used to order competing requests
	localparam int GC_WIDTH = 8;

	localparam int LATENCY_ADD = 6; // adder pipe depth
	localparam int CNT_WIDTH = $clog2(LATENCY_ADD) + 1;

endpackage

//--- logic/rename_regfile.sv
`timescale 1ns/1ns

module rename_regfile
	import regfile_pkg::*;
	import acc_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [REG_WIDTH-1:0] r0,
	input logic [REG_WIDTH-1:0] r1,
	input logic [REG_WIDTH-1:0] r2,
	input logic issue,
	input logic [ROB_WIDTH-1:0] issue_tag,
	input logic commit,
	input logic [REG_WIDTH-1:0] commit_num,
	input logic [ROB_WIDTH-1:0] commit_tag,
	input logic [31:0] commit_data,
	input logic [N_ACC-1:0] acc_wr,
	input logic [N_ACC-1:0][31:0] acc_result,
	output logic [1:0] rd_valid,
	output logic [1:0][ROB_WIDTH-1:0] rd_tag,
	output logic [1:0][31:0] rd_data,
	output logic [N_ACC-1:0][31:0] acc_value
);

	logic [N_REG-1:0] valid_q;
	logic [ROB_WIDTH-1:0] tag_q [N_REG];
	logic [31:0] data_q [N_REG];
	logic commit_wr;

	// data only lands on the register that is still waiting for this tag
	assign commit_wr = commit && !valid_q[commit_num] && tag_q[commit_num] == commit_tag;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '1;
		end else begin
			for (int i = 0; i < N_REG; i++) begin
				if (issue && r0 == i) begin
					valid_q[i] <= 1'b0; // renamed, wait for the new producer
				end else if (commit && tag_q[i] == commit_tag) begin
					valid_q[i] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			tag_q[r0] <= issue_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < N_REG; i++) begin
				data_q[i] <= (i == REG_SP) ? REG_SP_INIT :
				             (i == REG_HP) ? REG_HP_INIT : 32'h0;
			end
		end else begin
			if (commit_wr) begin
				data_q[commit_num] <= commit_data;
			end
			// accumulator writeback comes last so it overrides a commit
			for (int a = 0; a < N_ACC; a++) begin
				if (acc_wr[a]) begin
					data_q[N_REG-N_ACC+a] <= acc_result[a];
				end
			end
		end
	end

	assign rd_valid[0] = valid_q[r1];
	assign rd_tag[0] = tag_q[r1];
	assign rd_data[0] = data_q[r1];

	assign rd_valid[1] = valid_q[r2];
	assign rd_tag[1] = tag_q[r2];
	assign rd_data[1] = data_q[r2];

	always_comb begin
		for (int a = 0; a < N_ACC; a++) begin
			acc_value[a] = data_q[N_REG-N_ACC+a]; // operand a of the adder pipe
		end
	end

endmodule

//--- logic/acc_dispatch.sv
`timescale 1ns/1ns

module acc_dispatch
	import acc_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic gd_sign,
	input logic [N_CORE-1:0] req_valid,
	input logic [N_CORE-1:0][31:0] req_data,
	input logic [N_CORE-1:0][GC_WIDTH-1:0] stamp,
	output logic [N_CORE-1:0] req_ready,
	output logic op_valid,
	output logic [31:0] op_data,
	output logic busy_low
);

	logic [$clog2(N_CORE)-1:0] win;
	logic found;
	logic signed [GC_WIDTH-1:0] best;
	logic [CNT_WIDTH-1:0] count;

	// scan upward and replace only on a strict win, so ties keep the lower index
	always_comb begin
		found = 1'b0;
		win = '0;
		best = '0;
		for (int c = 0; c < N_CORE; c++) begin
			if (req_valid[c] && (!found ||
			    (gd_sign ? $signed(stamp[c]) > best : $signed(stamp[c]) < best))) begin
				found = 1'b1;
				win = c[$clog2(N_CORE)-1:0];
				best = stamp[c];
			end
		end
	end

	// counter at 1 means the result writes back this cycle and can be bypassed
	assign busy_low = count <= 1;

	for (genvar c = 0; c < N_CORE; c++) begin : g_ready
		assign req_ready[c] = busy_low && found && win == c;
	end

	assign op_valid = |(req_valid & req_ready);
	assign op_data = req_data[win];

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (op_valid) begin
			count <= CNT_WIDTH'(LATENCY_ADD);
		end else if (count != 0) begin
			count <= count - 1'b1;
		end
	end

endmodule

//--- logic/acc_adder_pipe.sv
`timescale 1ns/1ns

module acc_adder_pipe
	import acc_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic [31:0] acc_in,
	input logic [31:0] operand,
	input logic [31:0] bypass_value,
	output logic out_valid,
	output logic [31:0] sum
);

	logic [31:0] a_sel;
	logic [LATENCY_ADD-1:0] valid_q;
	logic [16:0] lo_q; // low half sum with carry out
	logic [15:0] a_hi_q;
	logic [15:0] b_hi_q;
	logic [31:0] sum_q [LATENCY_ADD-1:1];

	// result leaving the pipe this cycle is the newest accumulator value
	assign a_sel = out_valid ? bypass_value : acc_in;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[LATENCY_ADD-2:0], in_valid};
		end
	end

	always_ff @(posedge clk) begin
		lo_q <= {1'b0, a_sel[15:0]} + {1'b0, operand[15:0]};
		a_hi_q <= a_sel[31:16];
		b_hi_q <= operand[31:16];
		sum_q[1] <= {a_hi_q + b_hi_q + {15'h0, lo_q[16]}, lo_q[15:0]};
		for (int s = 2; s < LATENCY_ADD; s++) begin
			sum_q[s] <= sum_q[s-1]; // pad to the full adder latency
		end
	end

	assign out_valid = valid_q[LATENCY_ADD-1];
	assign sum = sum_q[LATENCY_ADD-1];

endmodule

//--- logic/regfile_top.sv
`timescale 1ns/1ns

module regfile_top
	import regfile_pkg::*;
	import acc_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [REG_WIDTH-1:0] r0,
	input logic [REG_WIDTH-1:0] r1,
	input logic [REG_WIDTH-1:0] r2,
	input logic issue,
	input logic [ROB_WIDTH-1:0] issue_tag,
	input logic commit,
	input logic [REG_WIDTH-1:0] commit_num,
	input logic [ROB_WIDTH-1:0] commit_tag,
	input logic [31:0] commit_data,
	input logic gd_sign,
	input logic [N_CORE-1:0][N_ACC-1:0] acc_req_valid,
	input logic [N_CORE-1:0][N_ACC-1:0][31:0] acc_data,
	input logic [N_CORE-1:0][N_ACC-1:0][GC_WIDTH-1:0] gc_stamp,
	output logic [1:0] rd_valid,
	output logic [1:0][ROB_WIDTH-1:0] rd_tag,
	output logic [1:0][31:0] rd_data,
	output logic [N_CORE-1:0][N_ACC-1:0] acc_req_ready,
	output logic no_acc_req,
	output logic acc_idle
);

	logic [N_ACC-1:0] op_valid;
	logic [N_ACC-1:0][31:0] op_data;
	logic [N_ACC-1:0] busy_low;
	logic [N_ACC-1:0][31:0] acc_value;
	logic [N_ACC-1:0] acc_wr;
	logic [N_ACC-1:0][31:0] acc_result;

	rename_regfile u_regfile (
		.clk(clk), .reset(reset),
		.r0(r0), .r1(r1), .r2(r2),
		.issue(issue), .issue_tag(issue_tag),
		.commit(commit), .commit_num(commit_num),
		.commit_tag(commit_tag), .commit_data(commit_data),
		.acc_wr(acc_wr), .acc_result(acc_result),
		.rd_valid(rd_valid), .rd_tag(rd_tag), .rd_data(rd_data),
		.acc_value(acc_value)
	);

	for (genvar a = 0; a < N_ACC; a++) begin : g_acc
		logic [N_CORE-1:0] req_valid;
		logic [N_CORE-1:0][31:0] req_data;
		logic [N_CORE-1:0][GC_WIDTH-1:0] stamp;
		logic [N_CORE-1:0] req_ready;

		// regroup the core-major request arrays per accumulator
		for (genvar c = 0; c < N_CORE; c++) begin : g_core
			assign req_valid[c] = acc_req_valid[c][a];
			assign req_data[c] = acc_data[c][a];
			assign stamp[c] = gc_stamp[c][a];
			assign acc_req_ready[c][a] = req_ready[c];
		end

		acc_dispatch u_dispatch (
			.clk(clk), .reset(reset), .gd_sign(gd_sign),
			.req_valid(req_valid), .req_data(req_data), .stamp(stamp),
			.req_ready(req_ready), .op_valid(op_valid[a]),
			.op_data(op_data[a]), .busy_low(busy_low[a])
		);

		acc_adder_pipe u_adder (
			.clk(clk), .reset(reset), .in_valid(op_valid[a]),
			.acc_in(acc_value[a]), .operand(op_data[a]),
			.bypass_value(acc_result[a]), // own sum fed back
			.out_valid(acc_wr[a]), .sum(acc_result[a])
		);
	end

	assign no_acc_req = ~|acc_req_valid;
	assign acc_idle = &busy_low;

endmodule

//--- sim/regfile_sva.sv
`timescale 1ns/1ns

module regfile_sva
	import acc_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [N_CORE-1:0][N_ACC-1:0] acc_req_valid,
	input logic [N_CORE-1:0][N_ACC-1:0] acc_req_ready,
	input logic [N_ACC-1:0] op_valid,
	input logic [N_ACC-1:0] acc_wr
);

	for (genvar a = 0; a < N_ACC; a++) begin : g_acc
		logic [N_CORE-1:0] valid;
		logic [N_CORE-1:0] ready;

		for (genvar c = 0; c < N_CORE; c++) begin : g_core
			assign valid[c] = acc_req_valid[c][a];
			assign ready[c] = acc_req_ready[c][a];
		end

		a_one_ready: assert property (@(posedge clk) disable iff (reset) $onehot0(ready))
			else $error("accumulator %0d grants more than one ready", a);

		a_ready_valid: assert property (@(posedge clk) disable iff (reset) (ready & ~valid) == '0)
			else $error("accumulator %0d raises ready without valid", a);

		// result strobe exactly when a dispatch happened LATENCY_ADD edges earlier
		a_result_timing: assert property (@(posedge clk) disable iff (reset)
			acc_wr[a] == $past(op_valid[a], LATENCY_ADD))
			else $error("accumulator %0d result strobe off the adder latency", a);
	end

endmodule

bind regfile_top regfile_sva u_sva (
	.clk(clk), .reset(reset),
	.acc_req_valid(acc_req_valid), .acc_req_ready(acc_req_ready),
	.op_valid(op_valid), .acc_wr(acc_wr)
);

//--- sim/regfile_tb.sv
`timescale 1ns/1ns

module regfile_tb
	import regfile_pkg::*;
	import acc_pkg::*;
;

	localparam int CLK_PERIOD = 4;
	localparam int TEST_CYCLES = 130;
	localparam int MARGIN_CYCLES = 70;

	logic clk;
	logic reset;
	logic [REG_WIDTH-1:0] r0, r1, r2;
	logic issue;
	logic [ROB_WIDTH-1:0] issue_tag;
	logic commit;
	logic [REG_WIDTH-1:0] commit_num;
	logic [ROB_WIDTH-1:0] commit_tag;
	logic [31:0] commit_data;
	logic gd_sign;
	logic [N_CORE-1:0][N_ACC-1:0] acc_req_valid;
	logic [N_CORE-1:0][N_ACC-1:0][31:0] acc_data;
	logic [N_CORE-1:0][N_ACC-1:0][GC_WIDTH-1:0] gc_stamp;
	logic [1:0] rd_valid;
	logic [1:0][ROB_WIDTH-1:0] rd_tag;
	logic [1:0][31:0] rd_data;
	logic [N_CORE-1:0][N_ACC-1:0] acc_req_ready;
	logic no_acc_req;
	logic acc_idle;
	logic [31:0] lfsr = 32'hfdf3f2c4;
	logic [31:0] acc_sum [N_ACC]; // accumulator contents from the operands sent so far

	regfile_top DUT (
		.clk(clk), .reset(reset), .r0(r0), .r1(r1), .r2(r2),
		.issue(issue), .issue_tag(issue_tag), .commit(commit), .commit_num(commit_num),
		.commit_tag(commit_tag), .commit_data(commit_data), .gd_sign(gd_sign),
		.acc_req_valid(acc_req_valid), .acc_data(acc_data), .gc_stamp(gc_stamp),
		.rd_valid(rd_valid), .rd_tag(rd_tag), .rd_data(rd_data),
		.acc_req_ready(acc_req_ready), .no_acc_req(no_acc_req), .acc_idle(acc_idle)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// sp and hp come out of reset preset, everything else clears
	function automatic logic [31:0] reset_value(input int n);
		if (n == int'(REG_SP)) begin
			return REG_SP_INIT;
		end else if (n == int'(REG_HP)) begin
			return REG_HP_INIT;
		end
		return 32'h0;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic check(input string name, input logic [63:0] expected, input logic [63:0] actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
			$display("TB FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	// both read ports look at the same register and must agree
	task automatic read_reg(input int num);
		r1 = REG_WIDTH'(num);
		r2 = REG_WIDTH'(num);
		#1;
		check($sformatf("read ports r%0d", num), {rd_valid[1], rd_tag[1], rd_data[1]},
		      {rd_valid[0], rd_tag[0], rd_data[0]});
	endtask

	// returns one ns after the edge that took the transfer
	task automatic wait_ready(input string name, input int c, input int a);
		logic [N_CORE-1:0] col;
		int waited;
		col = '0;
		waited = 0;
		while (col == '0) begin
			#1;
			for (int i = 0; i < N_CORE; i++) begin
				col[i] = acc_req_ready[i][a];
			end
			check({name, " no_acc_req"}, 0, no_acc_req); // request pending
			step();
			waited++;
			if (col == '0 && waited > 2 * LATENCY_ADD) begin
				abort_run($sformatf("%s: requester %0d never got ready", name, c));
			end
		end
		check({name, " ready"}, 64'(1 << c), 64'(col));
	endtask

	task automatic reset_values();
		int m;
		for (int n = 0; n < N_REG; n++) begin
			m = N_REG - 1 - n; // second port reads from the other end
			r1 = REG_WIDTH'(n);
			r2 = REG_WIDTH'(m);
			#1;
			check($sformatf("reset valid r%0d", n), 1, rd_valid[0]);
			check($sformatf("reset data r%0d", n), reset_value(n), rd_data[0]);
			check($sformatf("reset valid port 2 r%0d", m), 1, rd_valid[1]);
			check($sformatf("reset data port 2 r%0d", m), reset_value(m), rd_data[1]);
			step();
		end
		#1;
		check("reset no_acc_req", 1, no_acc_req);
		check("reset acc_idle", 1, acc_idle);
		step();
	endtask

	task automatic rename_commit();
		logic [ROB_WIDTH-1:0] tag;
		logic [31:0] data;
		tag = ROB_WIDTH'(rand_bits(ROB_WIDTH));
		data = rand_bits(32);
		r0 = 5'd5;
		issue = 1'b1;
		issue_tag = tag;
		step();
		issue = 1'b0;
		read_reg(5);
		check("rename valid", 0, rd_valid[0]);
		check("rename tag", 64'(tag), 64'(rd_tag[0]));
		step();
		commit = 1'b1;
		commit_num = 5'd5;
		commit_tag = tag ^ 4'h1; // some other producer
		commit_data = data;
		step();
		commit = 1'b0;
		read_reg(5);
		check("foreign commit valid", 0, rd_valid[0]);
		check("foreign commit data", 0, rd_data[0]);
		step();
		commit = 1'b1;
		commit_tag = tag;
		step();
		commit = 1'b0;
		read_reg(5);
		check("matching commit valid", 1, rd_valid[0]);
		check("matching commit data", data, rd_data[0]);
		step();
	endtask

	task automatic stale_commit();
		logic [ROB_WIDTH-1:0] tag_a;
		logic [ROB_WIDTH-1:0] tag_b;
		logic [31:0] data_a;
		logic [31:0] data_b;
		tag_a = ROB_WIDTH'(rand_bits(ROB_WIDTH));
		tag_b = tag_a + 1'b1;
		data_a = rand_bits(32);
		data_b = rand_bits(32);
		r0 = 5'd9;
		issue = 1'b1;
		issue_tag = tag_a;
		step();
		issue_tag = tag_b; // renamed again before the first producer finished
		step();
		issue = 1'b0;
		commit = 1'b1;
		commit_num = 5'd9;
		commit_tag = tag_a;
		commit_data = data_a;
		step();
		commit = 1'b0;
		read_reg(9);
		check("stale commit valid", 0, rd_valid[0]);
		check("stale commit tag", 64'(tag_b), 64'(rd_tag[0]));
		check("stale commit data", 0, rd_data[0]);
		step();
		commit = 1'b1;
		commit_tag = tag_b;
		commit_data = data_b;
		step();
		commit = 1'b0;
		read_reg(9);
		check("newest commit valid", 1, rd_valid[0]);
		check("newest commit data", data_b, rd_data[0]);
		step();
	endtask

	task automatic single_accumulate();
		logic [31:0] old_val;
		logic [31:0] op;
		op = rand_bits(32);
		old_val = acc_sum[0];
		step();
		acc_req_valid[2][0] = 1'b1;
		acc_data[2][0] = op;
		gc_stamp[2][0] = GC_WIDTH'(rand_bits(GC_WIDTH));
		wait_ready("single accumulate", 2, 0);
		acc_req_valid[2][0] = 1'b0;
		for (int k = 1; k <= LATENCY_ADD; k++) begin
			step();
			read_reg(N_REG - N_ACC);
			check($sformatf("single accumulate after edge T+%0d", k),
			      (k < LATENCY_ADD) ? old_val : old_val + op, rd_data[0]);
		end
		acc_sum[0] = old_val + op;
		step();
	endtask

	task automatic arbitrate(input logic sign);
		logic [GC_WIDTH-1:0] st [N_CORE];
		logic [31:0] dat [N_CORE];
		logic [N_CORE-1:0] left;
		logic [31:0] total;
		int order [N_CORE];
		int best;
		gd_sign = sign;
		total = acc_sum[1];
		step();
		for (int c = 0; c < N_CORE; c++) begin
			st[c] = GC_WIDTH'(rand_bits(GC_WIDTH));
			dat[c] = rand_bits(32);
		end
		st[N_CORE-1] = st[1]; // tie, index 1 must go first
		left = '1;
		for (int k = 0; k < N_CORE; k++) begin
			best = -1;
			for (int c = 0; c < N_CORE; c++) begin
				if (left[c] && (best < 0 || (sign ? $signed(st[c]) > $signed(st[best])
				                                  : $signed(st[c]) < $signed(st[best])))) begin
					best = c;
				end
			end
			order[k] = best;
			left[best] = 1'b0;
			total = total + dat[best];
		end
		for (int c = 0; c < N_CORE; c++) begin
			acc_req_valid[c][1] = 1'b1;
			acc_data[c][1] = dat[c];
			gc_stamp[c][1] = st[c];
		end
		for (int k = 0; k < N_CORE; k++) begin
			wait_ready($sformatf("arbitrate sign %0d grant %0d", sign, k), order[k], 1);
			acc_req_valid[order[k]][1] = 1'b0;
		end
		repeat (LATENCY_ADD) step(); // last sum lands
		read_reg(N_REG - N_ACC + 1);
		check($sformatf("arbitrate sign %0d total", sign), total, rd_data[0]);
		acc_sum[1] = total;
		step();
	endtask

	task automatic status_flags();
		#1;
		check("status idle no_acc_req", 1, no_acc_req);
		check("status idle acc_idle", 1, acc_idle);
		step();
		acc_req_valid[0][1] = 1'b1;
		acc_data[0][1] = rand_bits(32);
		gc_stamp[0][1] = GC_WIDTH'(rand_bits(GC_WIDTH));
		wait_ready("status", 0, 1);
		acc_req_valid[0][1] = 1'b0;
		for (int k = 0; k < LATENCY_ADD; k++) begin
			#1;
			check($sformatf("status no_acc_req after edge T+%0d", k), 1, no_acc_req);
			check($sformatf("status acc_idle after edge T+%0d", k), k >= LATENCY_ADD - 1, acc_idle);
			step();
		end
	endtask

	initial begin
		#((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		abort_run("timeout: the tests did not finish before the watchdog expired");
	end

	initial begin
		reset = 1'b1;
		r0 = '0;
		r1 = '0;
		r2 = '0;
		issue = 1'b0;
		issue_tag = '0;
		commit = 1'b0;
		commit_num = '0;
		commit_tag = '0;
		commit_data = '0;
		gd_sign = 1'b0;
		acc_req_valid = '0;
		acc_data = '0;
		gc_stamp = '0;
		acc_sum = '{default: 32'h0}; // accumulators clear on reset
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		reset_values();
		rename_commit();
		stale_commit();
		single_accumulate();
		arbitrate(1'b1);
		arbitrate(1'b0);
		status_flags();
		$display("TB PASSED");
		$finish;
	end

endmodule

//--- regfile_top.f
logic/regfile_pkg.sv
logic/acc_pkg.sv
logic/rename_regfile.sv
logic/acc_dispatch.sv
logic/acc_adder_pipe.sv
logic/regfile_top.sv
sim/regfile_sva.sv
sim/regfile_tb.sv

//--- Makefile
VERILATOR = verilator
TOP = regfile_tb
FILELIST = regfile_top.f
OBJDIR = obj_dir
FLAGS = --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJDIR)
LINT_FLAGS = --lint-only --timing -Wall --top-module $(TOP)
PASS_MSG = TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
